//--- design/llc_consts.svh
`ifndef LLC_CONSTS_SVH
`define LLC_CONSTS_SVH

// cache geometry
`define LLC_WAYS        4
`define LLC_SETS        16
`define LLC_SET_BITS    4
`define LLC_TAG_BITS    9
`define LLC_WAY_BITS    2
`define LINE_BITS       32

`define INVALID         1'b0
`define VALID           1'b1

`define INSTR           1'b0
`define DATA            1'b1

// word address fields
`define ADDR_SET_LSB    2
`define ADDR_TAG_LSB    6
`define ADDR_REGION_BIT 14  // instr region, also top tag bit
`define ADDR_CTRL_BIT   15  // write here starts a flush

`endif

//--- design/llc_pkg.sv
`default_nettype none
`include "llc_consts.svh"

package llc_pkg;

    typedef logic                        llc_state_t;
    typedef logic                        hprot_t;
    typedef logic [`LINE_BITS-1:0]       line_t;
    typedef logic [`LLC_TAG_BITS-1:0]    llc_tag_t;
    typedef logic [`LLC_SET_BITS-1:0]    llc_set_t;
    typedef logic [`LLC_WAY_BITS-1:0]    llc_way_t;

    // one way of one set, 44 bits
    typedef struct packed {
        llc_state_t state;
        hprot_t     hprot;
        logic       dirty;
        llc_tag_t   tag;
        line_t      line;
    } llc_entry_t;

    typedef struct packed {
        logic     write;
        logic     flush;
        hprot_t   hprot;
        llc_set_t set;
        llc_tag_t tag;
        line_t    line;  // write data
    } llc_req_t;

    // wishbone master to slave
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

//--- design/llc_wb_front.sv
`timescale 1ns/1ps
`default_nettype none
`include "llc_consts.svh"

module llc_wb_front
    import llc_pkg::*;
(
    input  wire          clk,
    input  wire          is_rst_to_resume,
    input  wire wb_req_t wb_req,
    input  wire          req_done,
    input  wire line_t   rsp_line,
    output wb_rsp_t      wb_rsp,
    output logic         req_valid,
    output llc_req_t     req
);

    logic        sel;
    logic        pending;  // request handed to controller
    logic        ack_q;
    logic [31:0] dat_q;

    assign sel = wb_req.cyc && wb_req.stb;
    assign req_valid = sel && !ack_q;  // master still holds stb in ack cycle
    assign wb_rsp = '{ack: ack_q, dat: dat_q};

    always_comb begin
        req.write = wb_req.we && !wb_req.adr[`ADDR_CTRL_BIT];
        req.flush = wb_req.we && wb_req.adr[`ADDR_CTRL_BIT];
        req.hprot = wb_req.adr[`ADDR_REGION_BIT] ? `INSTR : `DATA;
        req.set   = wb_req.adr[`ADDR_SET_LSB +: `LLC_SET_BITS];
        req.tag   = wb_req.adr[`ADDR_TAG_LSB +: `LLC_TAG_BITS];
        req.line  = wb_req.dat;
    end

    always_ff @(posedge clk) begin
        if (is_rst_to_resume) begin
            pending <= 1'b0;
            ack_q   <= 1'b0;
        end else begin
            ack_q <= req_done && pending && sel;  // single cycle ack
            if (req_done) begin
                pending <= 1'b0;
            end else if (req_valid) begin
                pending <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_done) begin
            dat_q <= rsp_line;
        end
    end

    // master must keep cyc/stb up until it has seen the ack
    ap_ack_in_cycle: assert property (@(posedge clk) disable iff (is_rst_to_resume)
        ack_q |-> sel);

endmodule

`default_nettype wire

//--- design/llc_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "llc_consts.svh"

module llc_ctrl
    import llc_pkg::*;
(
    input  wire             clk,
    input  wire             is_rst_to_resume,
    input  wire             req_valid,
    input  wire llc_req_t   req,
    input  wire llc_entry_t ways_buf [`LLC_WAYS],
    input  wire llc_way_t   evict_way_buf,
    input  wire             hit,
    input  wire llc_way_t   hit_way,
    input  wire             incr_rst_flush_stalled_set,
    output logic            req_done,
    output line_t           rsp_line,
    output llc_set_t        rd_set,
    output llc_set_t        cur_set,
    output logic            buf_load,
    output logic            buf_wr,
    output llc_way_t        buf_wr_way,
    output llc_entry_t      buf_wr_entry,
    output llc_way_t        update_evict_way_next,
    output logic            update_en,
    output logic            resume_rst,
    output logic            resume_flush,
    output logic            resume_req,
    output logic            update_evict_way,
    output llc_way_t        way
);

    typedef enum logic [3:0] {
        ST_RST, ST_IDLE,
        ST_REQ_SET, ST_REQ_LOAD, ST_REQ_EDIT, ST_REQ_UPD,
        ST_FL_READ, ST_FL_LOAD, ST_FL_UPD
    } ctrl_state_t;

    ctrl_state_t state;
    llc_req_t    req_q;
    llc_set_t    set_q;
    llc_way_t    way_q;
    logic        evict_upd_q;
    logic        last_set;

    assign last_set = set_q == llc_set_t'(`LLC_SETS - 1);

    always_ff @(posedge clk) begin
        if (is_rst_to_resume) begin
            state       <= ST_RST;
            set_q       <= '0;
            evict_upd_q <= 1'b0;
        end else begin
            case (state)
                ST_RST: if (incr_rst_flush_stalled_set) begin
                    set_q <= set_q + llc_set_t'(1);
                    if (last_set) state <= ST_IDLE;
                end
                ST_IDLE: if (req_valid) begin
                    state <= req.flush ? ST_FL_READ : ST_REQ_SET;
                    set_q <= req.flush ? '0 : req.set;
                end
                ST_REQ_SET:  state <= ST_REQ_LOAD;
                ST_REQ_LOAD: state <= ST_REQ_EDIT;
                ST_REQ_EDIT: begin
                    evict_upd_q <= !hit;  // pointer moves on allocation only
                    state       <= ST_REQ_UPD;
                end
                ST_REQ_UPD:  state <= ST_IDLE;
                ST_FL_READ:  state <= ST_FL_LOAD;
                ST_FL_LOAD:  state <= ST_FL_UPD;
                ST_FL_UPD: if (incr_rst_flush_stalled_set) begin
                    set_q <= set_q + llc_set_t'(1);
                    state <= last_set ? ST_IDLE : ST_FL_READ;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && req_valid) begin
            req_q <= req;
        end
        if (state == ST_REQ_EDIT) begin
            way_q <= buf_wr_way;
        end
    end

    // hit keeps the way, miss takes the way under the eviction pointer
    always_comb begin
        buf_wr_way            = hit ? hit_way : evict_way_buf;
        buf_wr_entry          = ways_buf[buf_wr_way];
        update_evict_way_next = evict_way_buf;
        if (hit) begin
            if (req_q.write) begin
                buf_wr_entry.line  = req_q.line;
                buf_wr_entry.dirty = 1'b1;
            end
        end else begin
            buf_wr_entry.state    = `VALID;
            buf_wr_entry.hprot    = req_q.hprot;
            buf_wr_entry.dirty    = req_q.write;
            buf_wr_entry.tag      = req_q.tag;
            buf_wr_entry.line     = req_q.write ? req_q.line : '0;  // no backing memory
            update_evict_way_next = evict_way_buf + llc_way_t'(1);
        end
    end

    assign rd_set           = set_q;
    assign cur_set          = set_q;
    assign buf_load         = (state == ST_REQ_LOAD) || (state == ST_FL_LOAD);
    assign buf_wr           = state == ST_REQ_EDIT;
    assign resume_rst       = state == ST_RST;
    assign resume_flush     = state == ST_FL_UPD;
    assign resume_req       = state == ST_REQ_UPD;
    assign update_en        = resume_rst || resume_flush || resume_req;
    assign update_evict_way = evict_upd_q;
    assign way              = way_q;
    assign req_done         = resume_req || (resume_flush && last_set);
    assign rsp_line         = resume_req ? ways_buf[way_q].line : '0;

    // edited way holds the request tag by the time it is written back
    ap_req_hits_edit: assert property (@(posedge clk) disable iff (is_rst_to_resume)
        resume_req |-> hit && hit_way == way);

endmodule

`default_nettype wire

//--- design/llc_set_buf.sv
`timescale 1ns/1ps
`default_nettype none
`include "llc_consts.svh"

module llc_set_buf
    import llc_pkg::*;
(
    input  wire             clk,
    input  wire llc_entry_t rd_data [`LLC_WAYS],
    input  wire llc_way_t   rd_evict,
    input  wire             buf_load,
    input  wire             buf_wr,
    input  wire llc_way_t   buf_wr_way,
    input  wire llc_entry_t buf_wr_entry,
    input  wire llc_way_t   evict_next,
    input  wire llc_tag_t   req_tag,
    output llc_entry_t      ways_buf [`LLC_WAYS],
    output llc_way_t        evict_way_buf,
    output logic            hit,
    output llc_way_t        hit_way
);

    always_ff @(posedge clk) begin
        if (buf_load) begin
            ways_buf      <= rd_data;  // whole set from storage
            evict_way_buf <= rd_evict;
        end else if (buf_wr) begin
            ways_buf[buf_wr_way] <= buf_wr_entry;
            evict_way_buf        <= evict_next;
        end
    end

    // parallel tag compare, lowest way wins
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = `LLC_WAYS - 1; w >= 0; w--) begin
            if (ways_buf[w].state == `VALID && ways_buf[w].tag == req_tag) begin
                hit     = 1'b1;
                hit_way = llc_way_t'(w);
            end
        end
    end

endmodule

`default_nettype wire

//--- design/llc_update.sv
`timescale 1ns/1ps
`default_nettype none
`include "llc_consts.svh"

module llc_update
    import llc_pkg::*;
(
    input  wire                  update_en,
    input  wire                  resume_rst,
    input  wire                  resume_flush,
    input  wire                  resume_req,
    input  wire                  update_evict_way,
    input  wire llc_entry_t      ways_buf [`LLC_WAYS],
    input  wire llc_way_t        evict_way_buf,
    input  wire llc_way_t        way,
    output logic                 wr_en,
    output logic                 wr_en_evict_way,
    output llc_entry_t           wr_data,
    output llc_way_t             wr_data_evict_way,
    output logic [`LLC_WAYS-1:0] wr_rst_flush,
    output logic                 incr_rst_flush_stalled_set
);

    always_comb begin
        wr_en                      = 1'b0;
        wr_en_evict_way            = 1'b0;
        wr_rst_flush               = '0;
        wr_data                    = '0;
        wr_data.state              = `INVALID;
        wr_data_evict_way          = '0;
        incr_rst_flush_stalled_set = 1'b0;
        if (update_en) begin
            if (resume_rst) begin
                wr_rst_flush               = {`LLC_WAYS{1'b1}};  // all ways, pointer to 0
                wr_en_evict_way            = 1'b1;
                incr_rst_flush_stalled_set = 1'b1;
            end else if (resume_flush) begin
                incr_rst_flush_stalled_set = 1'b1;
                for (int w = 0; w < `LLC_WAYS; w++) begin
                    if (ways_buf[w].state == `VALID && ways_buf[w].hprot == `DATA) begin
                        wr_rst_flush[w] = 1'b1;  // instr lines survive
                    end
                end
            end else if (resume_req) begin
                wr_en             = 1'b1;
                wr_data           = ways_buf[way];
                wr_data_evict_way = evict_way_buf;
                wr_en_evict_way   = update_evict_way;
            end
        end
    end

    // a request writes back only a line that the edit made valid
    ap_req_wr_valid: assert final (!wr_en || wr_data.state == `VALID);

endmodule

`default_nettype wire

//--- design/llc_way_mem.sv
`timescale 1ns/1ps
`default_nettype none
`include "llc_consts.svh"

module llc_way_mem
    import llc_pkg::*;
#(
    parameter type payload_t = llc_entry_t,
    parameter int  NUM_WAYS  = `LLC_WAYS,
    localparam int WAY_W     = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1
) (
    input  wire                clk,
    input  wire llc_set_t      rd_set,
    input  wire llc_set_t      wr_set,
    input  wire                wr_en,
    input  wire [WAY_W-1:0]    wr_way,
    input  wire [NUM_WAYS-1:0] wr_mask,
    input  wire payload_t      wr_data,
    output payload_t           rd_data [NUM_WAYS]
);

    payload_t mem [`LLC_SETS][NUM_WAYS];

    // one read and one write per cycle, read returns old data on collision
    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (wr_mask[w] || (wr_en && wr_way == WAY_W'(w))) begin
                mem[wr_set][w] <= wr_data;
            end
            rd_data[w] <= mem[rd_set][w];
        end
    end

endmodule

`default_nettype wire

//--- design/llc_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "llc_consts.svh"

module llc_top
    import llc_pkg::*;
(
    input  wire          clk,
    input  wire          is_rst_to_resume,
    input  wire wb_req_t wb_req,
    output wb_rsp_t      wb_rsp
);

    logic                 req_valid;
    llc_req_t             req;
    logic                 req_done;
    line_t                rsp_line;
    llc_set_t             rd_set;
    llc_set_t             cur_set;
    logic                 buf_load;
    logic                 buf_wr;
    llc_way_t             buf_wr_way;
    llc_entry_t           buf_wr_entry;
    llc_way_t             update_evict_way_next;
    logic                 update_en;
    logic                 resume_rst;
    logic                 resume_flush;
    logic                 resume_req;
    logic                 update_evict_way;
    llc_way_t             way;
    llc_entry_t           ways_buf [`LLC_WAYS];
    llc_way_t             evict_way_buf;
    logic                 hit;
    llc_way_t             hit_way;
    logic                 wr_en;
    logic                 wr_en_evict_way;
    llc_entry_t           wr_data;
    llc_way_t             wr_data_evict_way;
    logic [`LLC_WAYS-1:0] wr_rst_flush;
    logic                 incr_rst_flush_stalled_set;
    llc_entry_t           rd_data [`LLC_WAYS];
    llc_way_t             evict_rd [1];

    llc_wb_front llc_wb_front_inst (
        .clk, .is_rst_to_resume, .wb_req, .req_done, .rsp_line,
        .wb_rsp, .req_valid, .req
    );

    llc_ctrl llc_ctrl_inst (
        .clk, .is_rst_to_resume, .req_valid, .req, .ways_buf, .evict_way_buf,
        .hit, .hit_way, .incr_rst_flush_stalled_set,
        .req_done, .rsp_line, .rd_set, .cur_set, .buf_load, .buf_wr, .buf_wr_way,
        .buf_wr_entry, .update_evict_way_next, .update_en, .resume_rst,
        .resume_flush, .resume_req, .update_evict_way, .way
    );

    llc_set_buf llc_set_buf_inst (
        .clk, .rd_data, .rd_evict(evict_rd[0]), .buf_load, .buf_wr, .buf_wr_way,
        .buf_wr_entry, .evict_next(update_evict_way_next), .req_tag(req.tag),
        .ways_buf, .evict_way_buf, .hit, .hit_way
    );

    llc_update llc_update_inst (
        .update_en, .resume_rst, .resume_flush, .resume_req, .update_evict_way,
        .ways_buf, .evict_way_buf, .way,
        .wr_en, .wr_en_evict_way, .wr_data, .wr_data_evict_way, .wr_rst_flush,
        .incr_rst_flush_stalled_set
    );

    llc_way_mem #(.payload_t(llc_entry_t), .NUM_WAYS(`LLC_WAYS)) entry_mem_inst (
        .clk, .rd_set, .wr_set(cur_set), .wr_en, .wr_way(way), .wr_mask(wr_rst_flush),
        .wr_data, .rd_data
    );

    // eviction pointer, one slot per set
    llc_way_mem #(.payload_t(llc_way_t), .NUM_WAYS(1)) evict_mem_inst (
        .clk, .rd_set, .wr_set(cur_set), .wr_en(wr_en_evict_way), .wr_way(1'b0),
        .wr_mask(1'b0), .wr_data(wr_data_evict_way), .rd_data(evict_rd)
    );

endmodule

`default_nettype wire

//--- testbench/llc_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "llc_consts.svh"

module llc_tb
    import llc_pkg::*;
();

    localparam int CLK_HALF       = 10;
    localparam int RST_CYCLES     = 10;
    localparam int RAND_OPS       = 300;
    localparam int TIMEOUT_CYCLES = 4000;  // ~360 ops at 8 cycles, two flushes, reset

    logic    clk = 1'b0;
    logic    is_rst_to_resume;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;
    integer  seed = 32'h0799a144;
    int      cycle_count = 0;
    int      error_count = 0;
    int      last_latency = 0;

    // reference model of the cache contents
    logic                     m_valid [`LLC_SETS][`LLC_WAYS];
    logic                     m_instr [`LLC_SETS][`LLC_WAYS];
    logic [`LLC_TAG_BITS-1:0] m_tag   [`LLC_SETS][`LLC_WAYS];
    logic [`LINE_BITS-1:0]    m_line  [`LLC_SETS][`LLC_WAYS];
    int                       m_ptr   [`LLC_SETS];

    always #(CLK_HALF) clk = ~clk;

    llc_top llc_top_inst (
        .clk,
        .is_rst_to_resume,
        .wb_req,
        .wb_rsp
    );

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("timeout: the run went past %0d cycles, the DUT stopped answering",
                     TIMEOUT_CYCLES);
            $display("Testbench failed");
            $fatal(1, "timeout");
        end
    end

    task automatic check_eq(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            $display("Testbench failed");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [31:0] make_addr(input logic [`LLC_TAG_BITS-1:0] tag,
                                              input logic [`LLC_SET_BITS-1:0] set_idx);
        make_addr = '0;
        make_addr[`ADDR_TAG_LSB +: `LLC_TAG_BITS] = tag;
        make_addr[`ADDR_SET_LSB +: `LLC_SET_BITS] = set_idx;
    endfunction

    task automatic model_reset();
        for (int s = 0; s < `LLC_SETS; s++) begin
            m_ptr[s] = 0;
            for (int w = 0; w < `LLC_WAYS; w++) begin
                m_valid[s][w] = 1'b0;
            end
        end
    endtask

    task automatic model_flush();
        for (int s = 0; s < `LLC_SETS; s++) begin
            for (int w = 0; w < `LLC_WAYS; w++) begin
                if (m_valid[s][w] && !m_instr[s][w]) begin
                    m_valid[s][w] = 1'b0;  // data lines only
                end
            end
        end
    endtask

    task automatic model_access(input logic we, input logic [31:0] adr,
                                input logic [31:0] dat, output logic [31:0] expected);
        int                       set_idx;
        int                       way_idx;
        logic [`LLC_TAG_BITS-1:0] tag;
        set_idx = adr[`ADDR_SET_LSB +: `LLC_SET_BITS];
        tag     = adr[`ADDR_TAG_LSB +: `LLC_TAG_BITS];
        way_idx = -1;
        for (int w = 0; w < `LLC_WAYS; w++) begin
            if (way_idx < 0 && m_valid[set_idx][w] && m_tag[set_idx][w] == tag) begin
                way_idx = w;
            end
        end
        if (way_idx < 0) begin
            way_idx = m_ptr[set_idx];  // round-robin victim
            m_valid[set_idx][way_idx] = 1'b1;
            m_instr[set_idx][way_idx] = adr[`ADDR_REGION_BIT];
            m_tag[set_idx][way_idx]   = tag;
            m_line[set_idx][way_idx]  = '0;  // nothing behind the cache
            m_ptr[set_idx] = (m_ptr[set_idx] + 1) % `LLC_WAYS;
        end
        if (we) begin
            m_line[set_idx][way_idx] = dat;
        end
        expected = m_line[set_idx][way_idx];
    endtask

    // call at a falling edge, returns one cycle after the ack
    task automatic run_bus_cycle(input logic we, input logic [31:0] adr,
                                 input logic [31:0] dat, output logic [31:0] rdata);
        int waited;
        waited = 0;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        do begin
            @(negedge clk);
            waited++;
        end while (wb_rsp.ack !== 1'b1);
        rdata        = wb_rsp.dat;
        last_latency = waited;
        @(negedge clk);  // hold through the ack edge
        check_eq("wb_rsp.ack one cycle after ack", wb_rsp.ack, 1'b0);
        wb_req = '0;
    endtask

    task automatic wb_write(input logic [31:0] adr, input logic [31:0] dat);
        logic [31:0] unused;
        @(negedge clk);
        run_bus_cycle(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input logic [31:0] adr, output logic [31:0] rdata);
        @(negedge clk);
        run_bus_cycle(1'b0, adr, '0, rdata);
    endtask

    task automatic wb_flush();
        logic [31:0] unused;
        @(negedge clk);
        run_bus_cycle(1'b1, 32'h1 << `ADDR_CTRL_BIT, '0, unused);
        model_flush();
    endtask

    task automatic write_model(input logic [31:0] adr, input logic [31:0] dat);
        logic [31:0] unused;
        wb_write(adr, dat);
        model_access(1'b1, adr, dat, unused);
    endtask

    task automatic read_expect(input logic [31:0] adr, output logic [31:0] got);
        logic [31:0] expected;
        wb_read(adr, got);
        model_access(1'b0, adr, '0, expected);
        check_eq($sformatf("wb_rsp.dat at adr 0x%08h", adr), got, expected);
    endtask

    task automatic test_reset_reads();
        logic [31:0] r;
        logic [31:0] adr;
        logic [31:0] got;
        logic [31:0] expected;
        model_reset();
        is_rst_to_resume = 1'b1;
        repeat (RST_CYCLES) @(negedge clk);
        is_rst_to_resume = 1'b0;
        r   = $random(seed);
        adr = make_addr({2'b00, r[6:0]}, r[10:7]);
        run_bus_cycle(1'b0, adr, '0, got);  // issued while the sweep runs
        model_access(1'b0, adr, '0, expected);
        check_eq("ack latency after reset", last_latency, `LLC_SETS + 5);
        check_eq("wb_rsp.dat after reset", got, expected);
        for (int i = 0; i < 7; i++) begin
            r   = $random(seed);
            adr = make_addr({2'b00, r[6:0]}, r[10:7]);
            read_expect(adr, got);
            check_eq("wb_rsp.dat after reset", got, 32'h0);
        end
    endtask

    task automatic test_write_read();
        logic [31:0] d_adr;
        logic [31:0] i_adr;
        logic [31:0] got;
        d_adr = make_addr(9'h081, 4'd3);
        i_adr = make_addr(9'h181, 4'd3);  // region bit set
        write_model(d_adr, 32'hcafe_0001);
        read_expect(d_adr, got);
        check_eq("ack latency", last_latency, 5);
        check_eq("wb_rsp.dat data line", got, 32'hcafe_0001);
        write_model(i_adr, 32'h1357_9bdf);
        read_expect(i_adr, got);
        check_eq("wb_rsp.dat instr line", got, 32'h1357_9bdf);
        read_expect(d_adr, got);
        check_eq("wb_rsp.dat data line", got, 32'hcafe_0001);
    endtask

    task automatic test_eviction();
        logic [31:0] got;
        for (int i = 0; i <= `LLC_WAYS; i++) begin
            write_model(make_addr(9'h090 + i, 4'd5), 32'he000_0000 + i);
        end
        for (int i = 1; i <= `LLC_WAYS; i++) begin
            read_expect(make_addr(9'h090 + i, 4'd5), got);
            check_eq("wb_rsp.dat kept line", got, 32'he000_0000 + i);
        end
        read_expect(make_addr(9'h090, 4'd5), got);  // oldest tag gone
        check_eq("wb_rsp.dat evicted line", got, 32'h0);
    endtask

    task automatic test_miss_alloc();
        logic [31:0] got;
        for (int i = 0; i < `LLC_WAYS; i++) begin
            read_expect(make_addr(9'h0a0 + i, 4'd7), got);
            check_eq("wb_rsp.dat read miss", got, 32'h0);
        end
        write_model(make_addr(9'h0a4, 4'd7), 32'ha4a4_0004);
        for (int i = 1; i < `LLC_WAYS; i++) begin
            read_expect(make_addr(9'h0a0 + i, 4'd7), got);
            check_eq("wb_rsp.dat allocated line", got, 32'h0);
        end
        read_expect(make_addr(9'h0a4, 4'd7), got);
        check_eq("wb_rsp.dat new line", got, 32'ha4a4_0004);
        read_expect(make_addr(9'h0a0, 4'd7), got);
        check_eq("wb_rsp.dat evicted line", got, 32'h0);
    endtask

    task automatic test_flush();
        logic [31:0] got;
        write_model(make_addr(9'h0b0, 4'd9), 32'hdada_00b0);
        write_model(make_addr(9'h0b1, 4'd9), 32'hdada_00b1);
        write_model(make_addr(9'h1b0, 4'd10), 32'h1111_01b0);
        write_model(make_addr(9'h1b1, 4'd10), 32'h1111_01b1);
        wb_flush();
        // instr lines first, a data miss may pick them as victims
        read_expect(make_addr(9'h181, 4'd3), got);
        check_eq("wb_rsp.dat instr after flush", got, 32'h1357_9bdf);
        read_expect(make_addr(9'h1b0, 4'd10), got);
        check_eq("wb_rsp.dat instr after flush", got, 32'h1111_01b0);
        read_expect(make_addr(9'h1b1, 4'd10), got);
        check_eq("wb_rsp.dat instr after flush", got, 32'h1111_01b1);
        read_expect(make_addr(9'h081, 4'd3), got);
        check_eq("wb_rsp.dat data after flush", got, 32'h0);
        read_expect(make_addr(9'h0b0, 4'd9), got);
        check_eq("wb_rsp.dat data after flush", got, 32'h0);
        read_expect(make_addr(9'h0b1, 4'd9), got);
        check_eq("wb_rsp.dat data after flush", got, 32'h0);
    endtask

    task automatic test_random_mix();
        logic [31:0] r;
        logic [31:0] d;
        logic [31:0] adr;
        logic [31:0] got;
        for (int i = 0; i < RAND_OPS; i++) begin
            r   = $random(seed);
            adr = make_addr({r[8], 5'b0, r[2:0]}, r[12:9]);  // small tag pool
            if (i == RAND_OPS / 2) begin
                wb_flush();
            end
            if (r[13]) begin
                d = $random(seed);
                write_model(adr, d);
            end else begin
                read_expect(adr, got);
            end
        end
    endtask

    initial begin
        is_rst_to_resume = 1'b1;
        wb_req           = '0;
        test_reset_reads();
        test_write_read();
        test_eviction();
        test_miss_alloc();
        test_flush();
        test_random_mix();
        if (error_count == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("Testbench failed");
            $fatal(1, "checks failed");
        end
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+design
design/llc_pkg.sv
design/llc_wb_front.sv
design/llc_ctrl.sv
design/llc_set_buf.sv
design/llc_update.sv
design/llc_way_mem.sv
design/llc_top.sv
testbench/llc_tb.sv

//--- Bender.yml
package:
  name: llc

sources:
  - include_dirs:
      - design
    files:
      - design/llc_pkg.sv
      - design/llc_wb_front.sv
      - design/llc_ctrl.sv
      - design/llc_set_buf.sv
      - design/llc_update.sv
      - design/llc_way_mem.sv
      - design/llc_top.sv

  - target: simulation
    include_dirs:
      - design
    files:
      - testbench/llc_tb.sv
